//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

	////////////////////
	// 640x480 @ 60 Hz timing

	// horizontal, in pixels
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC    = 96;
	localparam int H_TOTAL   = 800;

	// vertical, in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC    = 2;
	localparam int V_TOTAL   = 525;

	// pixel or line position
	typedef logic [9:0] coord_t;

	////////////////////
	// color

	// dac byte order, blue on top
	typedef struct packed {
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} rgb_t;

	localparam rgb_t COLOR_BLACK       = 24'h000000;
	localparam rgb_t COLOR_WHITE       = 24'hFFFFFF;
	localparam rgb_t COLOR_DARK_GREEN  = 24'h006400; // center hit
	localparam rgb_t COLOR_LIGHT_GREEN = 24'h90EE90; // ring hit
	localparam rgb_t COLOR_SPLASH      = 24'h32CD32;
	localparam rgb_t COLOR_BACKGROUND  = 24'h000040;

endpackage

`default_nettype wire

//--- panel_pkg.sv
`default_nettype none

package panel_pkg;

	////////////////////
	// screens, modes, slots

	// SCR_GAME kept so the encoding matches the board firmware
	typedef enum logic [1:0] {
		SCR_SPLASH = 2'd0,
		SCR_MAIN   = 2'd1,
		SCR_SL     = 2'd2,
		SCR_GAME   = 2'd3
	} screen_t;

	typedef enum logic [1:0] {
		MODE_SPLASH = 2'd0,
		MODE_MAIN   = 2'd1,
		MODE_SAVE   = 2'd2,
		MODE_LOAD   = 2'd3
	} mode_t;

	typedef enum logic [1:0] {
		SLOT_NONE = 2'd0,
		SLOT_1    = 2'd1,
		SLOT_2    = 2'd2,
		SLOT_3    = 2'd3
	} slot_t;

	// bit positions in the controller word
	localparam int BTN_BACK = 0;
	localparam int BTN_1    = 1;
	localparam int BTN_2    = 2;
	localparam int BTN_3    = 3;

	////////////////////
	// sensor word, three 5-bit pads, active low
	// top bit of each pad is the center, the rest the ring
	localparam int SENSOR_W = 15;
	localparam int PAD_BITS = 5;
	localparam int NUM_PADS = 3;

	typedef logic [SENSOR_W-1:0] sensor_t;

	// inside means lo < p < hi on both axes
	typedef struct packed {
		vga_pkg::coord_t x_lo;
		vga_pkg::coord_t x_hi;
		vga_pkg::coord_t y_lo;
		vga_pkg::coord_t y_hi;
	} rect_t;

	localparam rect_t PAD_RECT [0:NUM_PADS-1] = '{
		'{10'd154, 10'd193, 10'd198, 10'd247},
		'{10'd296, 10'd336, 10'd187, 10'd237},
		'{10'd447, 10'd489, 10'd198, 10'd247}
	};

	localparam rect_t MAIN_MASK [0:2] = '{
		'{10'd75, 10'd572, 10'd60, 10'd98},   // score banner
		'{10'd11, 10'd125, 10'd286, 10'd381}, // menu labels
		'{10'd0, 10'd75, 10'd0, 10'd33}       // back label, corner
	};
	// masks whose lower bounds are open (x>=0, y>=0)
	localparam logic [2:0] MAIN_MASK_OPEN = 3'b100;

	localparam rect_t SL_MASK [0:1] = '{
		'{10'd82, 10'd562, 10'd0, 10'd57},
		'{10'd11, 10'd125, 10'd286, 10'd381}
	};

endpackage

`default_nettype wire

//--- video_if.sv
`timescale 1ns/1ps
`default_nettype none

// raw timing from the counters, before the output register
interface video_if;
	logic            hs;
	logic            vs;
	logic            blank_n;
	vga_pkg::coord_t x;
	vga_pkg::coord_t y;

	modport source (
		output hs, vs, blank_n, x, y
	);

	modport sink (
		input hs, vs, blank_n, x, y
	);
endinterface

`default_nettype wire

//--- vga_sync_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vga_sync_gen (
	input  logic     VGA_CLK_n,
	input  logic     iRST_n,
	video_if.source  vid
);

	vga_pkg::coord_t h_cnt;
	vga_pkg::coord_t v_cnt;
	logic            h_last;
	logic            v_last;

	assign h_last = (h_cnt == vga_pkg::H_TOTAL - 1);
	assign v_last = (v_cnt == vga_pkg::V_TOTAL - 1);

	////////////////////
	// frame counters
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 10'd1;
				end
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
		end
	end

	////////////////////
	// decode
	assign vid.x = h_cnt;
	assign vid.y = v_cnt;

	assign vid.blank_n = (h_cnt < vga_pkg::H_VISIBLE) && (v_cnt < vga_pkg::V_VISIBLE);

	// negative sync pulses, after the front porch
	assign vid.hs = !((h_cnt >= vga_pkg::H_VISIBLE + vga_pkg::H_FRONT) &&
		(h_cnt < vga_pkg::H_VISIBLE + vga_pkg::H_FRONT + vga_pkg::H_SYNC));

	assign vid.vs = !((v_cnt >= vga_pkg::V_VISIBLE + vga_pkg::V_FRONT) &&
		(v_cnt < vga_pkg::V_VISIBLE + vga_pkg::V_FRONT + vga_pkg::V_SYNC));

endmodule

`default_nettype wire

//--- slot_select.sv
`timescale 1ns/1ps
`default_nettype none

// picks one of three slots while its menu is up
module slot_select (
	input  logic             VGA_CLK_n,
	input  logic             iRST_n,
	input  logic             active,
	input  logic [3:0]       buttons,
	output panel_pkg::slot_t slot
);

	panel_pkg::slot_t slot_d;

	// lowest button wins
	always_comb begin
		slot_d = slot;
		if (!active) begin
			slot_d = panel_pkg::SLOT_NONE;
		end else if (buttons[panel_pkg::BTN_1]) begin
			slot_d = panel_pkg::SLOT_1;
		end else if (buttons[panel_pkg::BTN_2]) begin
			slot_d = panel_pkg::SLOT_2;
		end else if (buttons[panel_pkg::BTN_3]) begin
			slot_d = panel_pkg::SLOT_3;
		end
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			slot <= panel_pkg::SLOT_NONE;
		end else begin
			slot <= slot_d;
		end
	end

endmodule

`default_nettype wire

//--- panel_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module panel_fsm (
	input  logic               VGA_CLK_n,
	input  logic               iRST_n,
	input  logic [3:0]         controller,
	input  panel_pkg::sensor_t sensor_input,
	output panel_pkg::screen_t screen,
	output panel_pkg::slot_t   save_signal,
	output panel_pkg::slot_t   load_signal,
	output panel_pkg::sensor_t sensor_input_to_save
);

	logic [3:0]       ctrl_q;
	panel_pkg::mode_t mode_q;
	panel_pkg::mode_t mode_d;
	logic             save_active;
	logic             load_active;

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q <= controller;
		end
	end

	////////////////////
	// mode machine
	always_comb begin
		mode_d = mode_q;
		case (mode_q)
			panel_pkg::MODE_SPLASH: begin
				if (|ctrl_q) mode_d = panel_pkg::MODE_MAIN;
			end
			panel_pkg::MODE_MAIN: begin
				if (ctrl_q[panel_pkg::BTN_2]) mode_d = panel_pkg::MODE_LOAD;
				else if (ctrl_q[panel_pkg::BTN_1]) mode_d = panel_pkg::MODE_SAVE;
			end
			default: begin // save or load menu
				if (ctrl_q[panel_pkg::BTN_BACK]) mode_d = panel_pkg::MODE_MAIN;
			end
		endcase
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			mode_q <= panel_pkg::MODE_SPLASH;
			screen <= panel_pkg::SCR_SPLASH;
		end else begin
			mode_q <= mode_d;
			case (mode_d)
				panel_pkg::MODE_SPLASH: screen <= panel_pkg::SCR_SPLASH;
				panel_pkg::MODE_MAIN:   screen <= panel_pkg::SCR_MAIN;
				default:                screen <= panel_pkg::SCR_SL;
			endcase
		end
	end

	// selectors live only while staying in the menu
	// so neither the entry press nor back picks a slot
	assign save_active = (mode_q == panel_pkg::MODE_SAVE) && (mode_d == panel_pkg::MODE_SAVE);
	assign load_active = (mode_q == panel_pkg::MODE_LOAD) && (mode_d == panel_pkg::MODE_LOAD);

	slot_select save_sel (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.active    (save_active),
		.buttons   (ctrl_q),
		.slot      (save_signal)
	);

	slot_select load_sel (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.active    (load_active),
		.buttons   (ctrl_q),
		.slot      (load_signal)
	);

	// sensor word being saved, frozen outside save mode
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			sensor_input_to_save <= '0;
		end else if (mode_q == panel_pkg::MODE_SAVE) begin
			sensor_input_to_save <= sensor_input;
		end
	end

endmodule

`default_nettype wire

//--- pixel_render.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_render (
	input  logic               VGA_CLK_n,
	input  logic               iRST_n,
	video_if.sink              vid,
	input  panel_pkg::screen_t screen,
	input  panel_pkg::sensor_t sensor_input,
	output logic               oHS,
	output logic               oVS,
	output logic               oBLANK_n,
	output logic [7:0]         r_data,
	output logic [7:0]         g_data,
	output logic [7:0]         b_data
);

	panel_pkg::sensor_t sensor_q;
	vga_pkg::rgb_t      color_d;
	vga_pkg::rgb_t      color_q;

	// strict bounds, unless the lower edge is open
	function automatic logic in_rect(
		input vga_pkg::coord_t x,
		input vga_pkg::coord_t y,
		input panel_pkg::rect_t r,
		input logic open_lo
	);
		logic x_ok;
		logic y_ok;
		x_ok = (open_lo || (x > r.x_lo)) && (x < r.x_hi);
		y_ok = (open_lo || (y > r.y_lo)) && (y < r.y_hi);
		return x_ok && y_ok;
	endfunction

	// center hit beats ring hit
	function automatic vga_pkg::rgb_t pad_color(
		input logic [panel_pkg::PAD_BITS-1:0] bits,
		input vga_pkg::rgb_t base
	);
		vga_pkg::rgb_t c;
		c = base;
		if (!bits[panel_pkg::PAD_BITS-1]) begin
			c = vga_pkg::COLOR_DARK_GREEN;
		end else if (!(&bits[panel_pkg::PAD_BITS-2:0])) begin
			c = vga_pkg::COLOR_LIGHT_GREEN;
		end
		return c;
	endfunction

	always_ff @(posedge VGA_CLK_n) begin
		sensor_q <= sensor_input;
	end

	////////////////////
	// color for the current counter state
	always_comb begin
		color_d = vga_pkg::COLOR_BACKGROUND;
		for (int k = 0; k < panel_pkg::NUM_PADS; k++) begin
			if (in_rect(vid.x, vid.y, panel_pkg::PAD_RECT[k], 1'b0)) begin
				color_d = pad_color(sensor_q[k*panel_pkg::PAD_BITS +: panel_pkg::PAD_BITS],
					color_d);
			end
		end

		// white masks over the menu artwork areas
		if (screen == panel_pkg::SCR_MAIN) begin
			for (int m = 0; m < 3; m++) begin
				if (in_rect(vid.x, vid.y, panel_pkg::MAIN_MASK[m],
						panel_pkg::MAIN_MASK_OPEN[m])) begin
					color_d = vga_pkg::COLOR_WHITE;
				end
			end
		end else if (screen == panel_pkg::SCR_SL) begin
			for (int m = 0; m < 2; m++) begin
				if (in_rect(vid.x, vid.y, panel_pkg::SL_MASK[m], 1'b0)) begin
					color_d = vga_pkg::COLOR_WHITE;
				end
			end
		end

		if (screen == panel_pkg::SCR_SPLASH) color_d = vga_pkg::COLOR_SPLASH;
		if (!vid.blank_n) color_d = vga_pkg::COLOR_BLACK; // porch and sync
	end

	////////////////////
	// output stage, sync and color stay aligned
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			oHS      <= 1'b1;
			oVS      <= 1'b1;
			oBLANK_n <= 1'b0;
			color_q  <= vga_pkg::COLOR_BLACK;
		end else begin
			oHS      <= vid.hs;
			oVS      <= vid.vs;
			oBLANK_n <= vid.blank_n;
			color_q  <= color_d;
		end
	end

	assign r_data = color_q.r;
	assign g_data = color_q.g;
	assign b_data = color_q.b;

endmodule

`default_nettype wire

//--- vga_controller.sv
`timescale 1ns/1ps
`default_nettype none

module vga_controller (
	input  logic                          VGA_CLK_n,
	input  logic                          iRST_n,
	input  logic [panel_pkg::SENSOR_W-1:0] sensor_input,
	input  logic [3:0]                    controller,
	output logic                          oHS,
	output logic                          oVS,
	output logic                          oBLANK_n,
	output logic [7:0]                    r_data,
	output logic [7:0]                    g_data,
	output logic [7:0]                    b_data,
	output logic [1:0]                    save_signal,
	output logic [1:0]                    load_signal,
	output logic [panel_pkg::SENSOR_W-1:0] sensor_input_to_save
);

	video_if            vid_bus ();
	panel_pkg::screen_t screen;

	vga_sync_gen u_sync (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.vid       (vid_bus)
	);

	panel_fsm u_fsm (
		.VGA_CLK_n            (VGA_CLK_n),
		.iRST_n               (iRST_n),
		.controller           (controller),
		.sensor_input         (sensor_input),
		.screen               (screen),
		.save_signal          (save_signal),
		.load_signal          (load_signal),
		.sensor_input_to_save (sensor_input_to_save)
	);

	pixel_render u_render (
		.VGA_CLK_n    (VGA_CLK_n),
		.iRST_n       (iRST_n),
		.vid          (vid_bus),
		.screen       (screen),
		.sensor_input (sensor_input),
		.oHS          (oHS),
		.oVS          (oVS),
		.oBLANK_n     (oBLANK_n),
		.r_data       (r_data),
		.g_data       (g_data),
		.b_data       (b_data)
	);

endmodule

`default_nettype wire

//--- tb_vga_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_controller;

	localparam int CLK_PERIOD   = 20;
	localparam int FRAME_CYCLES = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
	localparam int TEST_FRAMES  = 8;
	localparam longint TIMEOUT_NS = longint'(TEST_FRAMES) * FRAME_CYCLES * CLK_PERIOD + 200000;
	localparam int HS_START = vga_pkg::H_VISIBLE + vga_pkg::H_FRONT; // 656
	localparam int VS_START = vga_pkg::V_VISIBLE + vga_pkg::V_FRONT; // 490

	logic        VGA_CLK_n;
	logic        iRST_n;
	logic [14:0] sensor_input;
	logic [3:0]  controller;
	logic        oHS, oVS, oBLANK_n;
	logic [7:0]  r_data, g_data, b_data;
	logic [1:0]  save_signal, load_signal;
	logic [14:0] sensor_input_to_save;

	// reference model state
	int                 m_h, m_v;
	logic               exp_hs, exp_vs, exp_blank_n;
	vga_pkg::rgb_t      exp_color;
	logic [3:0]         m_ctrl_q;
	panel_pkg::mode_t   m_mode, m_mode_next;
	panel_pkg::slot_t   m_save, m_load;
	panel_pkg::sensor_t m_to_save, m_sensor_q;

	logic               checking;
	int                 error_count;
	panel_pkg::sensor_t held_word;

	vga_controller dut0 (
		.VGA_CLK_n            (VGA_CLK_n),
		.iRST_n               (iRST_n),
		.sensor_input         (sensor_input),
		.controller           (controller),
		.oHS                  (oHS),
		.oVS                  (oVS),
		.oBLANK_n             (oBLANK_n),
		.r_data               (r_data),
		.g_data               (g_data),
		.b_data               (b_data),
		.save_signal          (save_signal),
		.load_signal          (load_signal),
		.sensor_input_to_save (sensor_input_to_save)
	);

	initial begin
		VGA_CLK_n = 1'b0;
		forever #(CLK_PERIOD / 2) VGA_CLK_n = ~VGA_CLK_n;
	end

	////////////////////
	// model rules
	function automatic logic inside_rect(input int x, input int y, input panel_pkg::rect_t r);
		return (x > r.x_lo) && (x < r.x_hi) && (y > r.y_lo) && (y < r.y_hi);
	endfunction

	function automatic vga_pkg::rgb_t expected_color(input int h, input int v,
		input panel_pkg::mode_t mode, input panel_pkg::sensor_t s);
		vga_pkg::rgb_t c;
		logic [4:0]    pad;
		if (h >= vga_pkg::H_VISIBLE || v >= vga_pkg::V_VISIBLE) begin
			c = vga_pkg::COLOR_BLACK;
		end else if (mode == panel_pkg::MODE_SPLASH) begin
			c = vga_pkg::COLOR_SPLASH;
		end else begin
			c = vga_pkg::COLOR_BACKGROUND;
			for (int k = 0; k < 3; k++) begin
				pad = s[k*panel_pkg::PAD_BITS +: panel_pkg::PAD_BITS];
				if (inside_rect(h, v, panel_pkg::PAD_RECT[k])) begin
					if (!pad[4]) c = vga_pkg::COLOR_DARK_GREEN;
					else if (pad[3:0] != 4'hF) c = vga_pkg::COLOR_LIGHT_GREEN;
				end
			end
			if (mode == panel_pkg::MODE_MAIN) begin
				if (inside_rect(h, v, panel_pkg::MAIN_MASK[0]) ||
					inside_rect(h, v, panel_pkg::MAIN_MASK[1]) ||
					(h < panel_pkg::MAIN_MASK[2].x_hi && v < panel_pkg::MAIN_MASK[2].y_hi))
					c = vga_pkg::COLOR_WHITE; // corner mask has open lower edges
			end else if (inside_rect(h, v, panel_pkg::SL_MASK[0]) ||
				inside_rect(h, v, panel_pkg::SL_MASK[1])) begin
				c = vga_pkg::COLOR_WHITE;
			end
		end
		return c;
	endfunction

	function automatic panel_pkg::mode_t next_mode(input panel_pkg::mode_t mode,
		input logic [3:0] btn);
		panel_pkg::mode_t nm;
		nm = mode;
		case (mode)
			panel_pkg::MODE_SPLASH: if (btn != 4'd0) nm = panel_pkg::MODE_MAIN;
			panel_pkg::MODE_MAIN: begin
				if (btn[panel_pkg::BTN_2]) nm = panel_pkg::MODE_LOAD;
				else if (btn[panel_pkg::BTN_1]) nm = panel_pkg::MODE_SAVE;
			end
			default: if (btn[panel_pkg::BTN_BACK]) nm = panel_pkg::MODE_MAIN;
		endcase
		return nm;
	endfunction

	// slot only moves while the menu stays up
	function automatic panel_pkg::slot_t next_slot(input panel_pkg::slot_t cur,
		input logic stay, input logic [3:0] btn);
		if (!stay) return panel_pkg::SLOT_NONE;
		if (btn[panel_pkg::BTN_1]) return panel_pkg::SLOT_1;
		if (btn[panel_pkg::BTN_2]) return panel_pkg::SLOT_2;
		if (btn[panel_pkg::BTN_3]) return panel_pkg::SLOT_3;
		return cur;
	endfunction

	assign m_mode_next = next_mode(m_mode, m_ctrl_q);

	always @(posedge VGA_CLK_n) m_sensor_q <= sensor_input;

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			m_h         <= 0;
			m_v         <= 0;
			exp_hs      <= 1'b1;
			exp_vs      <= 1'b1;
			exp_blank_n <= 1'b0;
			exp_color   <= vga_pkg::COLOR_BLACK;
			m_ctrl_q    <= 4'd0;
			m_mode      <= panel_pkg::MODE_SPLASH;
			m_save      <= panel_pkg::SLOT_NONE;
			m_load      <= panel_pkg::SLOT_NONE;
			m_to_save   <= '0;
		end else begin
			exp_hs      <= !(m_h >= HS_START && m_h < HS_START + vga_pkg::H_SYNC);
			exp_vs      <= !(m_v >= VS_START && m_v < VS_START + vga_pkg::V_SYNC);
			exp_blank_n <= (m_h < vga_pkg::H_VISIBLE) && (m_v < vga_pkg::V_VISIBLE);
			exp_color   <= expected_color(m_h, m_v, m_mode, m_sensor_q);
			m_h <= (m_h == vga_pkg::H_TOTAL - 1) ? 0 : m_h + 1;
			if (m_h == vga_pkg::H_TOTAL - 1)
				m_v <= (m_v == vga_pkg::V_TOTAL - 1) ? 0 : m_v + 1;
			m_ctrl_q <= controller;
			m_mode   <= m_mode_next;
			m_save   <= next_slot(m_save, m_mode == panel_pkg::MODE_SAVE &&
				m_mode_next == panel_pkg::MODE_SAVE, m_ctrl_q);
			m_load   <= next_slot(m_load, m_mode == panel_pkg::MODE_LOAD &&
				m_mode_next == panel_pkg::MODE_LOAD, m_ctrl_q);
			if (m_mode == panel_pkg::MODE_SAVE) m_to_save <= sensor_input;
		end
	end

	////////////////////
	// checks
	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		error_count++;
		$display("[ERROR] %s expected %0h got %0h", name, exp, act);
		$display("Verification failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	// outputs settle after posedge, so compare on the falling edge
	always @(negedge VGA_CLK_n) begin
		if (checking) begin
			assert (oHS === exp_hs) else report_mismatch("oHS", exp_hs, oHS);
			assert (oVS === exp_vs) else report_mismatch("oVS", exp_vs, oVS);
			assert (oBLANK_n === exp_blank_n)
				else report_mismatch("oBLANK_n", exp_blank_n, oBLANK_n);
			assert (r_data === exp_color.r) else report_mismatch("r_data", exp_color.r, r_data);
			assert (g_data === exp_color.g) else report_mismatch("g_data", exp_color.g, g_data);
			assert (b_data === exp_color.b) else report_mismatch("b_data", exp_color.b, b_data);
			assert (save_signal === m_save)
				else report_mismatch("save_signal", m_save, save_signal);
			assert (load_signal === m_load)
				else report_mismatch("load_signal", m_load, load_signal);
			assert (sensor_input_to_save === m_to_save)
				else report_mismatch("sensor_input_to_save", m_to_save, sensor_input_to_save);
		end
	end

	////////////////////
	// stimulus helpers
	task automatic pulse_button(input int idx);
		@(negedge VGA_CLK_n);
		controller = 4'd1 << idx;
		@(negedge VGA_CLK_n);
		controller = 4'd0;
		repeat (2) @(negedge VGA_CLK_n); // ctrl_q, then mode and slots
	endtask

	// returns on the falling edge where the counters sit at 0,0
	task automatic next_frame();
		do @(negedge VGA_CLK_n); while (!(m_h == 0 && m_v == 0));
	endtask

	// one pad: no hit, center hit or ring-only hit
	function automatic logic [4:0] random_pad();
		logic [3:0]  ring;
		int unsigned pick;
		pick = $urandom % 3;
		ring = 4'($urandom);
		if (pick == 0) return 5'h1F;
		if (pick == 1) return {1'b0, ring};
		return {1'b1, (ring == 4'hF) ? 4'hE : ring};
	endfunction

	function automatic panel_pkg::sensor_t random_sensor();
		return {random_pad(), random_pad(), random_pad()};
	endfunction

	initial begin
		#(TIMEOUT_NS);
		$display("run timed out before the test sequence finished");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(37));
		error_count  = 0;
		checking     = 1'b0;
		iRST_n       = 1'b0;
		controller   = 4'd0;
		sensor_input = '1; // no hits
		@(negedge VGA_CLK_n);
		@(negedge VGA_CLK_n);
		checking = 1'b1;
		repeat (8) @(negedge VGA_CLK_n);
		iRST_n = 1'b1;

		next_frame(); // full splash frame
		pulse_button(panel_pkg::BTN_3);
		next_frame(); // main, idle pads

		repeat (3) begin
			sensor_input = random_sensor();
			next_frame();
		end

		// main ignores button 3 and back
		pulse_button(panel_pkg::BTN_3);
		pulse_button(panel_pkg::BTN_BACK);
		check_value("screen", panel_pkg::SCR_MAIN, dut0.u_fsm.screen);

		// save menu
		pulse_button(panel_pkg::BTN_1);
		check_value("save_signal", 0, save_signal);
		next_frame();
		sensor_input = random_sensor();
		pulse_button(panel_pkg::BTN_2);
		check_value("save_signal", 2, save_signal);
		check_value("sensor_input_to_save", sensor_input, sensor_input_to_save);
		pulse_button(panel_pkg::BTN_3);
		check_value("save_signal", 3, save_signal);
		pulse_button(panel_pkg::BTN_BACK);
		check_value("save_signal", 0, save_signal);
		held_word = sensor_input;
		next_frame();
		sensor_input = ~held_word;
		repeat (3) @(negedge VGA_CLK_n);
		check_value("sensor_input_to_save", held_word, sensor_input_to_save);

		// load menu
		pulse_button(panel_pkg::BTN_2);
		check_value("load_signal", 0, load_signal);
		pulse_button(panel_pkg::BTN_1);
		check_value("load_signal", 1, load_signal);
		check_value("save_signal", 0, save_signal);
		pulse_button(panel_pkg::BTN_BACK);
		check_value("load_signal", 0, load_signal);
		repeat (4) @(negedge VGA_CLK_n);

		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
vga_pkg.sv
panel_pkg.sv
video_if.sv
vga_sync_gen.sv
slot_select.sv
panel_fsm.sv
pixel_render.sv
vga_controller.sv
tb_vga_controller.sv
